//--- filelist.f
+incdir+verilog
verilog/core_pkg.sv
verilog/handshake.sv
verilog/decoder.sv
verilog/executor.sv
verilog/exec_top.sv
testbench/tb_exec.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_exec
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_exec.sv
`timescale 1ns/1ps

module tb_exec;

  // 300 iterative ops at the 66-cycle worst case, plus margin
  localparam int max_cycles = 30000;
  localparam int kind_reg   = 0;
  localparam int kind_load  = 1;
  localparam int kind_store = 2;

  logic               clk;
  logic               reset;
  logic               instr_valid;
  logic               instr_ready;
  logic [31:0]        instr;
  core_pkg::word_t    rs1_value;
  core_pkg::word_t    rs2_value;
  logic               result_valid;
  logic               result_ready;
  core_pkg::reg_idx_t rd;
  core_pkg::word_t    rd_data;
  core_pkg::mem_op_e  mem_op;
  core_pkg::word_t    mem_addr;
  core_pkg::word_t    mem_data;

  integer seed;
  int     cycles;
  int     errors;
  int     checks;
  int     tests;
  int     result_idx;
  string  test_name;

  // stimulus and expected results, in issue order
  logic [31:0]              word_q[$];
  core_pkg::word_t          a_q[$];
  core_pkg::word_t          b_q[$];
  core_pkg::executor_output exp_q[$];
  int                       kind_q[$];

  exec_top u_dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles, a result never arrived",
               max_cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic check_word(input string what, input core_pkg::word_t got,
                            input core_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @ %0t: %s #%0d %s got %h, expected %h", $time, test_name, result_idx,
               what, got, exp);
    end
  endtask

  task automatic check_reg(input string what, input core_pkg::reg_idx_t got,
                           input core_pkg::reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @ %0t: %s #%0d %s got %0d, expected %0d", $time, test_name, result_idx,
               what, got, exp);
    end
  endtask

  task automatic check_mem_op(input string what, input core_pkg::mem_op_e got,
                              input core_pkg::mem_op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @ %0t: %s #%0d %s got %s, expected %s", $time, test_name, result_idx,
               what, got.name(), exp.name());
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input core_pkg::reg_idx_t rd_idx);
    return {f7, 5'd2, 5'd1, f3, rd_idx, 7'b0110011};
  endfunction

  // reference for OP results, M extension included
  function automatic core_pkg::word_t op_result(input logic [6:0] f7, input logic [2:0] f3,
                                                input core_pkg::word_t a,
                                                input core_pkg::word_t b);
    logic [63:0]     p;
    logic            ovf;
    core_pkg::word_t q;
    ovf = a == 32'h8000_0000 && b == 32'hffff_ffff;
    if (f7 == 7'h20) begin
      if (f3 == 3'd0) return a - b;
      return $signed(a) >>> b[4:0];
    end
    if (f7 == 7'h00) begin
      case (f3)
        3'd0:    return a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
      endcase
    end
    case (f3)
      3'd0:    p = {32'b0, a} * {32'b0, b};
      3'd1:    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      3'd2:    p = {{32{a[31]}}, a} * {32'b0, b};
      default: p = {32'b0, a} * {32'b0, b};
    endcase
    if (f3 < 3'd4) return (f3 == 3'd0) ? p[31:0] : p[63:32];
    // zero divisor, then the signed overflow case
    if (b == '0) return f3[1] ? a : '1;
    if (ovf && !f3[0]) return f3[1] ? '0 : a;
    case (f3)
      3'd4:    q = $signed(a) / $signed(b);
      3'd5:    q = a / b;
      3'd6:    q = $signed(a) % $signed(b);
      default: q = a % b;
    endcase
    return q;
  endfunction

  task automatic queue_instr(input logic [31:0] word, input core_pkg::word_t a,
                             input core_pkg::word_t b);
    core_pkg::executor_output e;
    int                       kind;
    logic [2:0]               f3;
    logic [6:0]               f7;
    f3 = word[14:12];
    f7 = word[31:25];
    e = '0;
    kind = kind_reg;
    case (word[6:0])
      7'b0110011: begin
        if (f7 inside {7'h00, 7'h01} || (f7 == 7'h20 && f3 inside {3'd0, 3'd5})) begin
          e.rd = word[11:7];
          e.rd_data = op_result(f7, f3, a, b);
        end
      end
      7'b0110111: begin
        e.rd = word[11:7];
        e.rd_data = {word[31:12], 12'b0};
      end
      7'b0000011: begin
        kind = kind_load;
        case (f3)
          3'd0:    e.mem_op = core_pkg::mem_lb;
          3'd1:    e.mem_op = core_pkg::mem_lh;
          3'd2:    e.mem_op = core_pkg::mem_lw;
          3'd4:    e.mem_op = core_pkg::mem_lbu;
          3'd5:    e.mem_op = core_pkg::mem_lhu;
          default: kind = kind_reg;
        endcase
        if (kind == kind_load) begin
          e.rd = word[11:7];
          e.mem_addr = a + {{20{word[31]}}, word[31:20]};
        end
      end
      7'b0100011: begin
        kind = kind_store;
        e.mem_addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
        e.mem_data = b;
        case (f3)
          3'd0:    e.mem_op = core_pkg::mem_sb;
          3'd1:    e.mem_op = core_pkg::mem_sh;
          3'd2:    e.mem_op = core_pkg::mem_sw;
          default: kind = kind_reg;
        endcase
      end
      default: ;
    endcase
    word_q.push_back(word);
    a_q.push_back(a);
    b_q.push_back(b);
    exp_q.push_back(e);
    kind_q.push_back(kind);
  endtask

  task automatic compare_result();
    core_pkg::executor_output e;
    int                       kind;
    e = exp_q.pop_front();
    kind = kind_q.pop_front();
    check_reg("rd", rd, e.rd);
    check_mem_op("mem_op", mem_op, e.mem_op);
    if (kind == kind_reg) begin
      check_word("rd_data", rd_data, e.rd_data);
    end else begin
      check_word("mem_addr", mem_addr, e.mem_addr);
    end
    if (kind == kind_store) begin
      check_word("mem_data", mem_data, e.mem_data);
    end
  endtask

  // a stalled result must hold every port
  task automatic check_held(input core_pkg::executor_output held);
    if (!result_valid) begin
      errors++;
      $display("ERR @ %0t: %s #%0d result_valid dropped while stalled", $time, test_name,
               result_idx);
    end
    check_reg("held rd", rd, held.rd);
    check_word("held rd_data", rd_data, held.rd_data);
    check_mem_op("held mem_op", mem_op, held.mem_op);
    check_word("held mem_addr", mem_addr, held.mem_addr);
    check_word("held mem_data", mem_data, held.mem_data);
  endtask

  task automatic send_all();
    @(posedge clk);
    while (word_q.size() > 0) begin
      instr_valid <= 1'b1;
      instr <= word_q.pop_front();
      rs1_value <= a_q.pop_front();
      rs2_value <= b_q.pop_front();
      @(negedge clk);
      while (!instr_ready) @(negedge clk);
      @(posedge clk);
    end
    instr_valid <= 1'b0;
  endtask

  task automatic collect_results(input int count, input bit random_ready);
    int                       got;
    logic [31:0]              r;
    logic                     stalled;
    core_pkg::executor_output held;
    got = 0;
    stalled = 1'b0;
    held = '0;
    while (got < count) begin
      @(posedge clk);
      r = $random(seed);
      result_ready <= random_ready ? r[0] : 1'b1;
      @(negedge clk);
      result_idx = got;
      if (stalled) check_held(held);
      stalled = result_valid && !result_ready;
      if (result_valid && result_ready) begin
        compare_result();
        got++;
      end
      held.rd = rd;
      held.rd_data = rd_data;
      held.mem_op = mem_op;
      held.mem_addr = mem_addr;
      held.mem_data = mem_data;
    end
  endtask

  task automatic run_batch(input string name, input bit random_ready);
    int count;
    int c0;
    int e0;
    count = word_q.size();
    c0 = checks;
    e0 = errors;
    test_name = name;
    fork
      send_all();
      collect_results(count, random_ready);
    join
    @(posedge clk);
    result_ready <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      if (result_valid) begin
        errors++;
        $display("ERR @ %0t: %s gave a result beyond the %0d issued", $time, name, count);
      end
    end
    tests++;
    $display("%s: %0d results, %0d checks, %0d errors", name, count, checks - c0,
             errors - e0);
  endtask

  task automatic test_alu();
    logic [31:0] r;
    for (int op = 0; op < 10; op++) begin
      for (int n = 0; n < 20; n++) begin
        r = $random(seed);
        queue_instr(enc_r(op < 8 ? 7'h00 : 7'h20, op == 9 ? 3'd5 : 3'(op), r[4:0]),
                    $random(seed), $random(seed));
      end
    end
    run_batch("alu", 1'b0);
  endtask

  task automatic test_muldiv(input string name, input logic [2:0] first);
    core_pkg::word_t corner[4];
    logic [31:0]     r;
    corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 16; i++) begin
        queue_instr(enc_r(7'h01, first + 3'(f), 5'(i + 1)), corner[i / 4], corner[i % 4]);
      end
      for (int n = 0; n < 4; n++) begin
        r = $random(seed);
        // small divisors make the quotient interesting
        queue_instr(enc_r(7'h01, first + 3'(f), r[20:16]), $random(seed),
                    (n % 2 == 0) ? $random(seed) : {24'b0, r[15:8]});
      end
    end
    run_batch(name, 1'b0);
  endtask

  task automatic test_mem_lui();
    logic [2:0]  load_f3[5];
    logic [31:0] r;
    load_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    for (int n = 0; n < 20; n++) begin
      r = $random(seed);
      queue_instr({r[31:20], 5'd1, load_f3[n % 5], r[11:7], 7'b0000011},
                  $random(seed), $random(seed));
      r = $random(seed);
      queue_instr({r[31:25], 5'd2, 5'd1, 3'(n % 3), r[11:7], 7'b0100011},
                  $random(seed), $random(seed));
      r = $random(seed);
      queue_instr({r[31:12], r[11:7], 7'b0110111}, $random(seed), $random(seed));
    end
    // encodings outside the supported set
    r = $random(seed);
    queue_instr({r[31:7], 7'b0010011}, r, ~r);
    queue_instr({r[31:7], 7'b1100011}, r, ~r);
    queue_instr({7'h10, r[24:7], 7'b0110011}, r, ~r);
    queue_instr({7'h20, r[24:15], 3'd1, r[11:7], 7'b0110011}, r, ~r);
    run_batch("mem_lui", 1'b0);
  endtask

  task automatic test_back_pressure();
    logic [31:0] r;
    logic [31:0] w;
    for (int n = 0; n < 40; n++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0, 3'd1: w = enc_r(7'h00, r[10:8], r[15:11]);
        3'd2:       w = enc_r(7'h01, {1'b0, r[9:8]}, r[15:11]);
        3'd3:       w = enc_r(7'h01, {1'b1, r[9:8]}, r[15:11]);
        3'd4:       w = {r[31:20], 5'd1, 3'd2, r[15:11], 7'b0000011};
        3'd5:       w = {r[31:25], 5'd2, 5'd1, 3'd2, r[11:7], 7'b0100011};
        3'd6:       w = {r[31:12], r[15:11], 7'b0110111};
        default:    w = enc_r(7'h20, {r[8], 1'b0, r[8]}, r[15:11]);
      endcase
      queue_instr(w, $random(seed), $random(seed));
    end
    run_batch("back_pressure", 1'b1);
  endtask

  initial begin
    seed = 44;
    cycles = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    result_idx = 0;
    test_name = "reset";
    clk = 1'b0;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    rs1_value = '0;
    rs2_value = '0;
    result_ready = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    result_ready <= 1'b1;
    @(negedge clk);
    if (!instr_ready || result_valid) begin
      errors++;
      $display("ERR @ %0t: after reset instr_ready should be high, result_valid low", $time);
    end
    test_alu();
    test_muldiv("multiply", 3'd0);
    test_muldiv("divide", 3'd4);
    test_mem_lui();
    test_back_pressure();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/exec_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module exec_top (
  input  var logic                      clk,
  input  var logic                      reset,
  input  var logic                      instr_valid,
  output var logic                      instr_ready,
  input  var logic [`CORE_XLEN-1:0]     instr,
  input  var logic [`CORE_XLEN-1:0]     rs1_value,
  input  var logic [`CORE_XLEN-1:0]     rs2_value,
  output var logic                      result_valid,
  input  var logic                      result_ready,
  output var logic [`CORE_REG_BITS-1:0] rd,
  output var logic [`CORE_XLEN-1:0]     rd_data,
  output core_pkg::mem_op_e             mem_op,
  output var logic [`CORE_XLEN-1:0]     mem_addr,
  output var logic [`CORE_XLEN-1:0]     mem_data
);

  core_pkg::instr_u         instr_word;
  core_pkg::decoder_output  dec_out;
  core_pkg::executor_output exe_out;
  logic                     decoder_valid;
  logic                     executor_ready;

  assign instr_word = instr;

  decoder u_decoder (
    .clk            (clk),
    .reset          (reset),
    .instr_valid    (instr_valid),
    .instr_ready    (instr_ready),
    .instr          (instr_word),
    .rs1_value      (rs1_value),
    .rs2_value      (rs2_value),
    .decoder_valid  (decoder_valid),
    .executor_ready (executor_ready),
    .out            (dec_out)
  );

  executor u_executor (
    .clk            (clk),
    .reset          (reset),
    .decoder_valid  (decoder_valid),
    .executor_ready (executor_ready),
    .executor_valid (result_valid),
    .accessor_ready (result_ready),
    .in             (dec_out),
    .out            (exe_out)
  );

  // flatten result for the memory stage
  assign rd       = exe_out.rd;
  assign rd_data  = exe_out.rd_data;
  assign mem_op   = exe_out.mem_op;
  assign mem_addr = exe_out.mem_addr;
  assign mem_data = exe_out.mem_data;

endmodule

//--- verilog/executor.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module executor (
  input  var logic                    clk,
  input  var logic                    reset,
  input  var logic                    decoder_valid,
  output var logic                    executor_ready,
  output var logic                    executor_valid,
  input  var logic                    accessor_ready,
  input  var core_pkg::decoder_output in,
  output core_pkg::executor_output    out
);

  typedef enum logic [1:0] {st_idle, st_mul, st_div} state_e;

  state_e            state;
  logic              busy;
  logic              load;
  logic [6:0]        step_count;
  core_pkg::alu_op_e cur_op;
  // multiplicand, or dividend shifting out while quotient bits shift in
  logic [64:0]       md_x;
  // multiplier or divisor
  logic [63:0]       md_y;
  // product or partial remainder
  logic [63:0]       md_acc;
  logic              neg_q;
  logic              neg_r;
  logic              div_zero;
  core_pkg::word_t   rs1;
  core_pkg::word_t   rs2;
  core_pkg::word_t   mag1;
  core_pkg::word_t   mag2;
  core_pkg::word_t   alu_result;
  core_pkg::word_t   md_result;
  logic [4:0]        shamt;
  logic              is_mul;
  logic              is_div;
  logic              signed_div;
  logic [32:0]       rem_shift;
  logic [32:0]       rem_diff;

  assign rs1   = in.reg_rs1;
  assign rs2   = in.reg_rs2;
  assign shamt = rs2[4:0];
  assign busy  = state != st_idle;

  handshake u_handshake (
    .clk          (clk),
    .reset        (reset),
    .input_valid  (decoder_valid),
    .output_ready (accessor_ready),
    .busy         (busy),
    .unit_ready   (executor_ready),
    .unit_valid   (executor_valid),
    .load         (load)
  );

  assign is_mul = in.alu_op inside {core_pkg::alu_mul, core_pkg::alu_mulh,
                                    core_pkg::alu_mulhsu, core_pkg::alu_mulhu};
  assign is_div = in.alu_op inside {core_pkg::alu_div, core_pkg::alu_divu,
                                    core_pkg::alu_rem, core_pkg::alu_remu};
  assign signed_div = in.alu_op inside {core_pkg::alu_div, core_pkg::alu_rem};

  // divider works on magnitudes
  assign mag1 = (signed_div && rs1[`CORE_XLEN-1]) ? -rs1 : rs1;
  assign mag2 = (signed_div && rs2[`CORE_XLEN-1]) ? -rs2 : rs2;

  // one restoring step; remainder stays below the divisor
  assign rem_shift = {md_acc[31:0], md_x[64]};
  assign rem_diff  = rem_shift - {1'b0, md_y[31:0]};

  always_comb begin
    case (in.alu_op)
      core_pkg::alu_add:    alu_result = rs1 + rs2;
      core_pkg::alu_sub:    alu_result = rs1 - rs2;
      core_pkg::alu_sll:    alu_result = rs1 << shamt;
      core_pkg::alu_slt:    alu_result = core_pkg::word_t'($signed(rs1) < $signed(rs2));
      core_pkg::alu_sltu:   alu_result = core_pkg::word_t'(rs1 < rs2);
      core_pkg::alu_xor:    alu_result = rs1 ^ rs2;
      core_pkg::alu_srl:    alu_result = rs1 >> shamt;
      core_pkg::alu_sra:    alu_result = $signed(rs1) >>> shamt;
      core_pkg::alu_or:     alu_result = rs1 | rs2;
      core_pkg::alu_and:    alu_result = rs1 & rs2;
      core_pkg::alu_pass_b: alu_result = rs2;
      default:              alu_result = '0;
    endcase
  end

  always_comb begin
    case (cur_op)
      core_pkg::alu_mul: md_result = md_acc[31:0];
      core_pkg::alu_mulh,
      core_pkg::alu_mulhsu,
      core_pkg::alu_mulhu: md_result = md_acc[63:32];
      // most negative / -1 already wraps back to itself
      core_pkg::alu_div,
      core_pkg::alu_divu: md_result = div_zero ? '1 : (neg_q ? -md_x[31:0] : md_x[31:0]);
      default:            md_result = neg_r ? -md_acc[31:0] : md_acc[31:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      step_count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (load) begin
            out.rd       <= in.rd;
            out.rd_data  <= alu_result;
            out.mem_op   <= in.mem_op;
            out.mem_addr <= in.mem_addr;
            out.mem_data <= rs2;
            cur_op       <= in.alu_op;
            md_acc       <= '0;
            if (is_mul) begin
              state      <= st_mul;
              step_count <= (in.alu_op == core_pkg::alu_mul) ? 7'(`MUL_STEPS_LO)
                                                              : 7'(`MUL_STEPS_HI);
              case (in.alu_op)
                core_pkg::alu_mulh: begin
                  md_x <= {{33{rs1[31]}}, rs1};
                  md_y <= {{32{rs2[31]}}, rs2};
                end
                core_pkg::alu_mulhsu: begin
                  md_x <= {{33{rs1[31]}}, rs1};
                  md_y <= {32'b0, rs2};
                end
                default: begin
                  md_x <= {33'b0, rs1};
                  md_y <= {32'b0, rs2};
                end
              endcase
            end else if (is_div) begin
              state      <= st_div;
              step_count <= 7'(`DIV_STEPS);
              md_x       <= {33'b0, mag1};
              md_y       <= {32'b0, mag2};
              neg_q      <= signed_div && (rs1[31] ^ rs2[31]);
              neg_r      <= signed_div && rs1[31];
              div_zero   <= rs2 == '0;
            end
          end
        end
        st_mul: begin
          if (step_count != '0) begin
            md_acc     <= md_y[0] ? md_acc + md_x[63:0] : md_acc;
            md_x       <= md_x << 1;
            md_y       <= md_y >> 1;
            step_count <= step_count - 7'd1;
          end else begin
            out.rd_data <= md_result;
            state       <= st_idle;
          end
        end
        st_div: begin
          if (step_count != '0) begin
            if (!rem_diff[32]) begin
              md_acc <= {32'b0, rem_diff[31:0]};
              md_x   <= {md_x[63:0], 1'b1};
            end else begin
              md_acc <= {32'b0, rem_shift[31:0]};
              md_x   <= {md_x[63:0], 1'b0};
            end
            step_count <= step_count - 7'd1;
          end else begin
            out.rd_data <= md_result;
            state       <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // a stalled result keeps its payload
  assert property (@(posedge clk) disable iff (reset)
    executor_valid && !accessor_ready |=> $stable(out));

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  var logic                    clk,
  input  var logic                    reset,
  input  var logic                    instr_valid,
  output var logic                    instr_ready,
  input  var core_pkg::instr_u        instr,
  input  var core_pkg::word_t         rs1_value,
  input  var core_pkg::word_t         rs2_value,
  output var logic                    decoder_valid,
  input  var logic                    executor_ready,
  output core_pkg::decoder_output     out
);

  localparam logic [6:0] opc_op    = 7'b0110011;
  localparam logic [6:0] opc_lui   = 7'b0110111;
  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;

  core_pkg::decoder_output dec;
  core_pkg::word_t         imm_i;
  core_pkg::word_t         imm_s;
  core_pkg::word_t         imm_u;
  logic                    load;

  handshake u_handshake (
    .clk          (clk),
    .reset        (reset),
    .input_valid  (instr_valid),
    .output_ready (executor_ready),
    .busy         (1'b0),
    .unit_ready   (instr_ready),
    .unit_valid   (decoder_valid),
    .load         (load)
  );

  assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  // store offset is split over funct7 and rd
  assign imm_s = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
  assign imm_u = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};

  always_comb begin
    dec         = '0;
    dec.alu_op  = core_pkg::alu_none;
    dec.mem_op  = core_pkg::mem_none;
    dec.reg_rs1 = rs1_value;
    dec.reg_rs2 = rs2_value;
    case (instr.r.opcode)
      opc_op: begin
        case (instr.r.funct7)
          7'b0000000: begin
            case (instr.r.funct3)
              3'b000:  dec.alu_op = core_pkg::alu_add;
              3'b001:  dec.alu_op = core_pkg::alu_sll;
              3'b010:  dec.alu_op = core_pkg::alu_slt;
              3'b011:  dec.alu_op = core_pkg::alu_sltu;
              3'b100:  dec.alu_op = core_pkg::alu_xor;
              3'b101:  dec.alu_op = core_pkg::alu_srl;
              3'b110:  dec.alu_op = core_pkg::alu_or;
              default: dec.alu_op = core_pkg::alu_and;
            endcase
          end
          7'b0100000: begin
            if (instr.r.funct3 == 3'b000) begin
              dec.alu_op = core_pkg::alu_sub;
            end else if (instr.r.funct3 == 3'b101) begin
              dec.alu_op = core_pkg::alu_sra;
            end
          end
          // M extension
          7'b0000001: begin
            case (instr.r.funct3)
              3'b000:  dec.alu_op = core_pkg::alu_mul;
              3'b001:  dec.alu_op = core_pkg::alu_mulh;
              3'b010:  dec.alu_op = core_pkg::alu_mulhsu;
              3'b011:  dec.alu_op = core_pkg::alu_mulhu;
              3'b100:  dec.alu_op = core_pkg::alu_div;
              3'b101:  dec.alu_op = core_pkg::alu_divu;
              3'b110:  dec.alu_op = core_pkg::alu_rem;
              default: dec.alu_op = core_pkg::alu_remu;
            endcase
          end
          default: dec.alu_op = core_pkg::alu_none;
        endcase
        if (dec.alu_op != core_pkg::alu_none) begin
          dec.rd = instr.r.rd;
        end
      end
      opc_lui: begin
        dec.rd      = instr.r.rd;
        dec.alu_op  = core_pkg::alu_pass_b;
        dec.reg_rs2 = imm_u;
      end
      opc_load: begin
        case (instr.i.funct3)
          3'b000:  dec.mem_op = core_pkg::mem_lb;
          3'b001:  dec.mem_op = core_pkg::mem_lh;
          3'b010:  dec.mem_op = core_pkg::mem_lw;
          3'b100:  dec.mem_op = core_pkg::mem_lbu;
          3'b101:  dec.mem_op = core_pkg::mem_lhu;
          default: dec.mem_op = core_pkg::mem_none;
        endcase
        if (dec.mem_op != core_pkg::mem_none) begin
          dec.rd       = instr.i.rd;
          dec.mem_addr = rs1_value + imm_i;
        end
      end
      opc_store: begin
        case (instr.r.funct3)
          3'b000:  dec.mem_op = core_pkg::mem_sb;
          3'b001:  dec.mem_op = core_pkg::mem_sh;
          3'b010:  dec.mem_op = core_pkg::mem_sw;
          default: dec.mem_op = core_pkg::mem_none;
        endcase
        dec.mem_addr = rs1_value + imm_s;
      end
      default: dec.alu_op = core_pkg::alu_none;
    endcase
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out <= dec;
    end
  end

endmodule

//--- verilog/handshake.sv
`timescale 1ns/1ps

module handshake (
  input  var logic clk,
  input  var logic reset,
  input  var logic input_valid,
  input  var logic output_ready,
  input  var logic busy,
  output var logic unit_ready,
  output var logic unit_valid,
  output var logic load
);

  // stage holds an item
  logic full;

  assign unit_valid = full && !busy;
  // accept when empty or when the held item leaves this cycle
  assign unit_ready = !busy && (!full || output_ready);
  assign load       = input_valid && unit_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (unit_valid && output_ready) begin
      full <= 1'b0;
    end
  end

  // stalled result must not be dropped
  assert property (@(posedge clk) disable iff (reset)
    unit_valid && !output_ready |=> unit_valid);

  // offered item stays up until taken
  assert property (@(posedge clk) disable iff (reset)
    input_valid && !unit_ready |=> input_valid);

endmodule

//--- verilog/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]     word_t;
  typedef logic [`CORE_REG_BITS-1:0] reg_idx_t;

  // register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } instr_r_t;

  // immediate layout
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and,
    alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
    alu_div, alu_divu, alu_rem, alu_remu,
    alu_pass_b, alu_none
  } alu_op_e;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_sb, mem_sh, mem_sw
  } mem_op_e;

  typedef struct packed {
    reg_idx_t rd;
    alu_op_e  alu_op;
    mem_op_e  mem_op;
    word_t    reg_rs1;
    word_t    reg_rs2;
    word_t    mem_addr;
  } decoder_output;

  typedef struct packed {
    reg_idx_t rd;
    word_t    rd_data;
    mem_op_e  mem_op;
    word_t    mem_addr;
    word_t    mem_data;
  } executor_output;

endpackage

//--- verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath widths
`define CORE_XLEN     32
`define CORE_REG_BITS 5

// iterative unit step counts
`define MUL_STEPS_LO  32
`define MUL_STEPS_HI  64
`define DIV_STEPS     65

`endif
